/* all.f */
+incdir+verilog
verilog/pdp_rdma_pkg.sv
verilog/reg_access_if.sv
verilog/csb_req_decode.sv
verilog/group_pointer_regs.sv
verilog/dual_reg_group.sv
verilog/cfg_output_select.sv
verilog/pdp_rdma_reg.sv
testbench/pdp_rdma_checker.sv
testbench/tb_pdp_rdma_reg.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_pdp_rdma_reg
FILELIST = all.f
OBJ_DIR  = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TESTS PASSED"

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* testbench/tb_pdp_rdma_reg.sv */
`include "pdp_rdma_defs.svh"

module tb_pdp_rdma_reg
  import pdp_rdma_pkg::*;
();

  localparam int NUM_REQ    = 400;
  localparam int MAX_CYCLES = NUM_REQ * 10 + 200;  // at most 7 cycles per request

  logic         autosa_core_clk;
  logic         autosa_core_rstn;
  csb_req_pd_t  csb2pdp_rdma_req_pd;
  logic         csb2pdp_rdma_req_pvld;
  logic         dp2reg_done;
  csb_resp_pd_t pdp_rdma2csb_resp_pd;
  logic         pdp_rdma2csb_resp_valid;
  cube_dim_t    reg2dp_cube_in_width;
  cube_dim_t    reg2dp_cube_in_height;
  cube_dim_t    reg2dp_cube_in_channel;
  reg_data_t    reg2dp_src_base_addr_low;
  reg_data_t    reg2dp_src_line_stride;
  logic         reg2dp_dma_en;
  logic         reg2dp_op_en;
  logic [1:0]   model_op_en;     // from the checker, keeps writes off armed groups
  logic         model_producer;
  int           error_count;
  int           check_count;

  pdp_rdma_reg pdp_rdma_reg_i (
    .autosa_core_clk, .autosa_core_rstn,
    .csb2pdp_rdma_req_pd, .csb2pdp_rdma_req_pvld,
    .pdp_rdma2csb_resp_pd, .pdp_rdma2csb_resp_valid,
    .dp2reg_done,
    .reg2dp_cube_in_width, .reg2dp_cube_in_height, .reg2dp_cube_in_channel,
    .reg2dp_src_base_addr_low, .reg2dp_src_line_stride,
    .reg2dp_dma_en, .reg2dp_op_en
  );

  pdp_rdma_checker chk_i (
    .autosa_core_clk, .autosa_core_rstn,
    .csb2pdp_rdma_req_pd, .csb2pdp_rdma_req_pvld, .dp2reg_done,
    .pdp_rdma2csb_resp_pd, .pdp_rdma2csb_resp_valid,
    .reg2dp_cube_in_width, .reg2dp_cube_in_height, .reg2dp_cube_in_channel,
    .reg2dp_src_base_addr_low, .reg2dp_src_line_stride,
    .reg2dp_dma_en, .reg2dp_op_en,
    .model_op_en, .model_producer, .error_count, .check_count
  );

  initial begin
    autosa_core_clk = 1'b0;
    forever #4 autosa_core_clk = ~autosa_core_clk;
  end

  // watchdog
  initial begin
    repeat (MAX_CYCLES) @(posedge autosa_core_clk);
    $display("timeout: traffic still running after %0d cycles", MAX_CYCLES);
    $display("checks %0d, errors %0d", check_count, error_count);
    $display("TESTS FAILED");
    $finish;
  end

  //////////////////////////////////////////////////
  // csb and done drivers
  //////////////////////////////////////////////////
  task automatic send_request(input logic write, input logic nposted,
                              input reg_offset_t off, input reg_data_t wdata);
    csb_req_pd_t pd;
    pd = '0;
    pd[62:56] = 7'($urandom);  // level/wrbe/srcpriv, ignored by the DUT
    pd[`PDP_RDMA_REQ_ADDR_MSB:0] = 22'(off >> 2);
    pd[`PDP_RDMA_REQ_WDAT_MSB:`PDP_RDMA_REQ_WDAT_LSB] = wdata;
    pd[`PDP_RDMA_REQ_WRITE_BIT]   = write;
    pd[`PDP_RDMA_REQ_NPOSTED_BIT] = nposted;
    @(posedge autosa_core_clk);
    csb2pdp_rdma_req_pd   <= pd;
    csb2pdp_rdma_req_pvld <= 1'b1;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge autosa_core_clk);
      csb2pdp_rdma_req_pvld <= 1'b0;
    end
  endtask

  // idle first so no write lands on the done edge
  task automatic pulse_done();
    idle_cycles(1);
    @(posedge autosa_core_clk);
    dp2reg_done <= 1'b1;
    @(posedge autosa_core_clk);
    dp2reg_done <= 1'b0;
  endtask

  function automatic reg_offset_t pick_offset();
    int sel;
    sel = $urandom_range(0, 9);
    case (sel)
      0:       return `PDP_RDMA_S_POINTER;
      1:       return `PDP_RDMA_S_STATUS;
      2:       return `PDP_RDMA_D_OP_ENABLE;
      3:       return `PDP_RDMA_D_CUBE_WIDTH;
      4:       return `PDP_RDMA_D_CUBE_HEIGHT;
      5:       return `PDP_RDMA_D_CUBE_CHANNEL;
      6:       return `PDP_RDMA_D_SRC_BASE_LOW;
      7:       return `PDP_RDMA_D_SRC_LINE_STRIDE;
      8:       return `PDP_RDMA_D_DMA_EN;
      default: return reg_offset_t'($urandom_range(9, 1023) << 2);  // unmapped 0x024..0xffc
    endcase
  endfunction

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////
  initial begin : stimulus
    reg_offset_t off;
    reg_data_t   wdata;
    logic        write;
    logic        nposted;
    autosa_core_rstn      = 1'b0;
    csb2pdp_rdma_req_pd   = '0;
    csb2pdp_rdma_req_pvld = 1'b0;
    dp2reg_done           = 1'b0;
    void'($urandom(32'h0684_84b5));
    repeat (8) @(posedge autosa_core_clk);
    autosa_core_rstn <= 1'b1;

    for (int i = 0; i < NUM_REQ; i++) begin
      off     = pick_offset();
      write   = 1'($urandom_range(0, 1));
      nposted = 1'($urandom_range(0, 1));
      wdata   = $urandom;
      if (off == `PDP_RDMA_D_OP_ENABLE) begin
        wdata[0] = ($urandom_range(0, 3) != 0);  // mostly arm
      end
      // producer's group locked while armed, read instead
      if (write && off >= `PDP_RDMA_DUAL_BASE && model_op_en[model_producer]) begin
        write = 1'b0;
      end
      send_request(write, nposted, off, wdata);
      // model lags the bus by a few edges
      if (write && (off == `PDP_RDMA_S_POINTER || off == `PDP_RDMA_D_OP_ENABLE)) begin
        idle_cycles(3);
      end
      if (model_op_en != '0 && $urandom_range(0, 7) == 0) begin
        pulse_done();
      end
    end
    idle_cycles(4);  // last response out
    @(negedge autosa_core_clk);  // checker done with the last edge

    $display("checks %0d, errors %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

/* testbench/pdp_rdma_checker.sv */
`include "pdp_rdma_defs.svh"

module pdp_rdma_checker
  import pdp_rdma_pkg::*;
(
  input  logic                            autosa_core_clk,
  input  logic                            autosa_core_rstn,
  input  csb_req_pd_t                     csb2pdp_rdma_req_pd,
  input  logic                            csb2pdp_rdma_req_pvld,
  input  logic                            dp2reg_done,
  input  csb_resp_pd_t                    pdp_rdma2csb_resp_pd,
  input  logic                            pdp_rdma2csb_resp_valid,
  input  cube_dim_t                       reg2dp_cube_in_width,
  input  cube_dim_t                       reg2dp_cube_in_height,
  input  cube_dim_t                       reg2dp_cube_in_channel,
  input  reg_data_t                       reg2dp_src_base_addr_low,
  input  reg_data_t                       reg2dp_src_line_stride,
  input  logic                            reg2dp_dma_en,
  input  logic                            reg2dp_op_en,
  output logic [`PDP_RDMA_GROUP_NUM-1:0]  model_op_en,     // armed groups, for stimulus
  output logic                            model_producer,
  output int                              error_count,
  output int                              check_count
);

  logic                             m_consumer;
  cube_dim_t                        m_width   [`PDP_RDMA_GROUP_NUM];
  cube_dim_t                        m_height  [`PDP_RDMA_GROUP_NUM];
  cube_dim_t                        m_channel [`PDP_RDMA_GROUP_NUM];
  reg_data_t                        m_base    [`PDP_RDMA_GROUP_NUM];
  reg_data_t                        m_stride  [`PDP_RDMA_GROUP_NUM];
  logic [`PDP_RDMA_GROUP_NUM-1:0]   m_dma_en;
  logic [`PDP_RDMA_OP_EN_DEPTH-1:0] m_pipe;       // launch delay of the consumer's op_en
  logic                             m_req_vld;    // request captured at the last edge
  csb_req_pd_t                      m_req_pd;
  logic                             m_resp_vld;   // response expected on the port now
  csb_resp_pd_t                     m_resp_pd;

  // idle / pending / running per group
  function automatic logic [1:0] status_of(input logic g);
    if (!model_op_en[g]) begin
      return GROUP_IDLE;
    end
    return (m_consumer == g) ? GROUP_RUNNING : GROUP_PENDING;
  endfunction

  // register map as software sees it, dual offsets hit the producer's group
  function automatic reg_data_t model_read(input reg_offset_t off);
    reg_data_t rd;
    logic      g;
    rd = '0;
    g  = model_producer;
    case (off)
      `PDP_RDMA_S_POINTER: begin
        rd[0]  = model_producer;
        rd[16] = m_consumer;
      end
      `PDP_RDMA_S_STATUS: begin
        rd[1:0]   = status_of(1'b0);
        rd[17:16] = status_of(1'b1);
      end
      `PDP_RDMA_D_OP_ENABLE:       rd[0] = model_op_en[g];
      `PDP_RDMA_D_CUBE_WIDTH:      rd = reg_data_t'(m_width[g]);
      `PDP_RDMA_D_CUBE_HEIGHT:     rd = reg_data_t'(m_height[g]);
      `PDP_RDMA_D_CUBE_CHANNEL:    rd = reg_data_t'(m_channel[g]);
      `PDP_RDMA_D_SRC_BASE_LOW:    rd = m_base[g];
      `PDP_RDMA_D_SRC_LINE_STRIDE: rd = m_stride[g];
      `PDP_RDMA_D_DMA_EN:          rd[0] = m_dma_en[g];
      default: ;  // unmapped reads zero
    endcase
    return rd;
  endfunction

  task automatic compare_value(input string name, input logic [33:0] exp, input logic [33:0] act);
    check_count++;
    if (exp !== act) begin
      error_count++;
      $display("ERR %s: expected %0h, actual %0h (time %0t)", name, exp, act, $time);
    end
  endtask

  //////////////////////////////////////////////////
  // compare, then advance the model one edge
  //////////////////////////////////////////////////
  always @(posedge autosa_core_clk) begin : model_step
    reg_offset_t                    off;
    reg_data_t                      wd;
    logic                           is_wr;
    logic                           g;
    logic [`PDP_RDMA_GROUP_NUM-1:0] op_en_n;
    if (!autosa_core_rstn) begin
      error_count = 0;
      check_count = 0;
      model_op_en    <= '0;
      model_producer <= 1'b0;
      m_consumer     <= 1'b0;
      m_width        <= '{default: '0};
      m_height       <= '{default: '0};
      m_channel      <= '{default: '0};
      m_base         <= '{default: '0};
      m_stride       <= '{default: '0};
      m_dma_en       <= '0;
      m_pipe         <= '0;
      m_req_vld      <= 1'b0;
      m_req_pd       <= '0;
      m_resp_vld     <= 1'b0;
      m_resp_pd      <= '0;
    end else begin
      // port values here are the ones from just before the edge
      compare_value("resp_valid", 34'(m_resp_vld), 34'(pdp_rdma2csb_resp_valid));
      if (m_resp_vld) begin
        compare_value("resp_pd", m_resp_pd, pdp_rdma2csb_resp_pd);
      end
      compare_value("cube_in_width", 34'(m_width[m_consumer]), 34'(reg2dp_cube_in_width));
      compare_value("cube_in_height", 34'(m_height[m_consumer]), 34'(reg2dp_cube_in_height));
      compare_value("cube_in_channel", 34'(m_channel[m_consumer]), 34'(reg2dp_cube_in_channel));
      compare_value("src_base_addr_low", 34'(m_base[m_consumer]), 34'(reg2dp_src_base_addr_low));
      compare_value("src_line_stride", 34'(m_stride[m_consumer]), 34'(reg2dp_src_line_stride));
      compare_value("dma_en", 34'(m_dma_en[m_consumer]), 34'(reg2dp_dma_en));
      compare_value("op_en", 34'(m_pipe[`PDP_RDMA_OP_EN_DEPTH-1]), 34'(reg2dp_op_en));

      off     = reg_offset_t'(m_req_pd[`PDP_RDMA_REQ_ADDR_MSB:0] << 2);  // word -> byte
      wd      = m_req_pd[`PDP_RDMA_REQ_WDAT_MSB:`PDP_RDMA_REQ_WDAT_LSB];
      is_wr   = m_req_vld & m_req_pd[`PDP_RDMA_REQ_WRITE_BIT];
      g       = model_producer;
      op_en_n = model_op_en;

      // read data reflects state before this edge's write
      m_resp_vld <= m_req_vld & (~is_wr | m_req_pd[`PDP_RDMA_REQ_NPOSTED_BIT]);
      if (m_req_vld && !is_wr) begin
        m_resp_pd <= {2'b00, model_read(off)};
      end else if (is_wr && m_req_pd[`PDP_RDMA_REQ_NPOSTED_BIT]) begin
        m_resp_pd <= {1'b1, 1'b0, 32'h0};  // wr ack, no error, no data
      end

      if (is_wr && off < `PDP_RDMA_DUAL_BASE) begin
        if (off == `PDP_RDMA_S_POINTER) begin
          model_producer <= wd[0];  // status is read only
        end
      end else if (is_wr && !model_op_en[g]) begin
        case (off)
          `PDP_RDMA_D_OP_ENABLE:       op_en_n[g] = wd[0];
          `PDP_RDMA_D_CUBE_WIDTH:      m_width[g]   <= wd[12:0];
          `PDP_RDMA_D_CUBE_HEIGHT:     m_height[g]  <= wd[12:0];
          `PDP_RDMA_D_CUBE_CHANNEL:    m_channel[g] <= wd[12:0];
          `PDP_RDMA_D_SRC_BASE_LOW:    m_base[g]    <= wd;
          `PDP_RDMA_D_SRC_LINE_STRIDE: m_stride[g]  <= wd;
          `PDP_RDMA_D_DMA_EN:          m_dma_en[g]  <= wd[0];
          default: ;
        endcase
      end

      // done moves the consumer on and kills the launch
      if (dp2reg_done) begin
        m_consumer          <= ~m_consumer;
        op_en_n[m_consumer] = 1'b0;
        m_pipe              <= '0;
      end else begin
        m_pipe <= {m_pipe[`PDP_RDMA_OP_EN_DEPTH-2:0], model_op_en[m_consumer]};
      end
      model_op_en <= op_en_n;

      m_req_vld <= csb2pdp_rdma_req_pvld;
      if (csb2pdp_rdma_req_pvld) begin
        m_req_pd <= csb2pdp_rdma_req_pd;
      end
    end
  end

endmodule

/* verilog/pdp_rdma_reg.sv */
`include "pdp_rdma_defs.svh"

module pdp_rdma_reg
  import pdp_rdma_pkg::*;
(
  input  logic          autosa_core_clk,
  input  logic          autosa_core_rstn,
  input  csb_req_pd_t   csb2pdp_rdma_req_pd,
  input  logic          csb2pdp_rdma_req_pvld,
  output csb_resp_pd_t  pdp_rdma2csb_resp_pd,
  output logic          pdp_rdma2csb_resp_valid,
  input  logic          dp2reg_done,
  output cube_dim_t     reg2dp_cube_in_width,
  output cube_dim_t     reg2dp_cube_in_height,
  output cube_dim_t     reg2dp_cube_in_channel,
  output reg_data_t     reg2dp_src_base_addr_low,
  output reg_data_t     reg2dp_src_line_stride,
  output logic          reg2dp_dma_en,
  output logic          reg2dp_op_en
);

  reg_access_if s_acc ();
  reg_access_if d_acc [`PDP_RDMA_GROUP_NUM] ();

  logic                           producer;
  logic                           consumer;
  logic [`PDP_RDMA_GROUP_NUM-1:0] grp_op_en;
  cube_dim_t                      grp_cube_in_width     [`PDP_RDMA_GROUP_NUM];
  cube_dim_t                      grp_cube_in_height    [`PDP_RDMA_GROUP_NUM];
  cube_dim_t                      grp_cube_in_channel   [`PDP_RDMA_GROUP_NUM];
  reg_data_t                      grp_src_base_addr_low [`PDP_RDMA_GROUP_NUM];
  reg_data_t                      grp_src_line_stride   [`PDP_RDMA_GROUP_NUM];
  logic                           grp_dma_en            [`PDP_RDMA_GROUP_NUM];

  // csb slave side
  csb_req_decode u_decode (
    .autosa_core_clk, .autosa_core_rstn,
    .csb2pdp_rdma_req_pd, .csb2pdp_rdma_req_pvld,
    .producer, .s_acc, .d_acc,
    .pdp_rdma2csb_resp_pd, .pdp_rdma2csb_resp_valid
  );

  // pointers and status
  group_pointer_regs u_pointer (
    .autosa_core_clk, .autosa_core_rstn,
    .acc (s_acc), .op_en (grp_op_en), .dp2reg_done,
    .producer, .consumer
  );

  // ping-pong groups
  for (genvar g = 0; g < `PDP_RDMA_GROUP_NUM; g++) begin : g_grp
    dual_reg_group #(.GROUP_ID (g)) u_group (
      .autosa_core_clk, .autosa_core_rstn,
      .acc               (d_acc[g]),
      .consumer, .dp2reg_done,
      .op_en             (grp_op_en[g]),
      .cube_in_width     (grp_cube_in_width[g]),
      .cube_in_height    (grp_cube_in_height[g]),
      .cube_in_channel   (grp_cube_in_channel[g]),
      .src_base_addr_low (grp_src_base_addr_low[g]),
      .src_line_stride   (grp_src_line_stride[g]),
      .dma_en            (grp_dma_en[g])
    );
  end

  // datapath outputs
  cfg_output_select u_select (
    .autosa_core_clk, .autosa_core_rstn,
    .consumer, .dp2reg_done,
    .op_en             (grp_op_en),
    .cube_in_width     (grp_cube_in_width),
    .cube_in_height    (grp_cube_in_height),
    .cube_in_channel   (grp_cube_in_channel),
    .src_base_addr_low (grp_src_base_addr_low),
    .src_line_stride   (grp_src_line_stride),
    .dma_en            (grp_dma_en),
    .reg2dp_cube_in_width, .reg2dp_cube_in_height, .reg2dp_cube_in_channel,
    .reg2dp_src_base_addr_low, .reg2dp_src_line_stride,
    .reg2dp_dma_en, .reg2dp_op_en
  );

endmodule

/* verilog/cfg_output_select.sv */
`include "pdp_rdma_defs.svh"

module cfg_output_select
  import pdp_rdma_pkg::*;
(
  input  logic                            autosa_core_clk,
  input  logic                            autosa_core_rstn,
  input  logic                            consumer,
  input  logic                            dp2reg_done,
  input  logic [`PDP_RDMA_GROUP_NUM-1:0]  op_en,
  input  cube_dim_t                       cube_in_width     [`PDP_RDMA_GROUP_NUM],
  input  cube_dim_t                       cube_in_height    [`PDP_RDMA_GROUP_NUM],
  input  cube_dim_t                       cube_in_channel   [`PDP_RDMA_GROUP_NUM],
  input  reg_data_t                       src_base_addr_low [`PDP_RDMA_GROUP_NUM],
  input  reg_data_t                       src_line_stride   [`PDP_RDMA_GROUP_NUM],
  input  logic                            dma_en            [`PDP_RDMA_GROUP_NUM],
  output cube_dim_t                       reg2dp_cube_in_width,
  output cube_dim_t                       reg2dp_cube_in_height,
  output cube_dim_t                       reg2dp_cube_in_channel,
  output reg_data_t                       reg2dp_src_base_addr_low,
  output reg_data_t                       reg2dp_src_line_stride,
  output logic                            reg2dp_dma_en,
  output logic                            reg2dp_op_en
);

  logic [`PDP_RDMA_OP_EN_DEPTH-1:0] op_en_pipe;

  //////////////////////////////////////////////////
  // consumer's fields to the datapath
  //////////////////////////////////////////////////
  assign reg2dp_cube_in_width     = cube_in_width[consumer];
  assign reg2dp_cube_in_height    = cube_in_height[consumer];
  assign reg2dp_cube_in_channel   = cube_in_channel[consumer];
  assign reg2dp_src_base_addr_low = src_base_addr_low[consumer];
  assign reg2dp_src_line_stride   = src_line_stride[consumer];
  assign reg2dp_dma_en            = dma_en[consumer];

  //////////////////////////////////////////////////
  // launch pipe
  //////////////////////////////////////////////////
  // gives the fields time to settle before op_en reaches the datapath
  always_ff @(posedge autosa_core_clk or negedge autosa_core_rstn) begin
    if (!autosa_core_rstn) begin
      op_en_pipe <= '0;
    end else if (dp2reg_done) begin
      op_en_pipe <= '0;  // kill in-flight launch
    end else begin
      op_en_pipe <= {op_en_pipe[`PDP_RDMA_OP_EN_DEPTH-2:0], op_en[consumer]};
    end
  end

  assign reg2dp_op_en = op_en_pipe[`PDP_RDMA_OP_EN_DEPTH-1];

endmodule

/* verilog/dual_reg_group.sv */
`include "pdp_rdma_defs.svh"

module dual_reg_group
  import pdp_rdma_pkg::*;
#(
  parameter int unsigned GROUP_ID = 0  // 0 or 1
) (
  input  logic          autosa_core_clk,
  input  logic          autosa_core_rstn,
  reg_access_if.target  acc,
  input  logic          consumer,
  input  logic          dp2reg_done,
  output logic          op_en,
  output cube_dim_t     cube_in_width,
  output cube_dim_t     cube_in_height,
  output cube_dim_t     cube_in_channel,
  output reg_data_t     src_base_addr_low,
  output reg_data_t     src_line_stride,
  output logic          dma_en
);

  logic is_consumer;
  logic wr_ok;

  assign is_consumer = (consumer == 1'(GROUP_ID));
  assign wr_ok       = acc.wr_en & ~op_en;  // armed group is locked

  //////////////////////////////////////////////////
  // op_en
  //////////////////////////////////////////////////
  always_ff @(posedge autosa_core_clk or negedge autosa_core_rstn) begin
    if (!autosa_core_rstn) begin
      op_en <= 1'b0;
    end else if (wr_ok && acc.offset == `PDP_RDMA_D_OP_ENABLE) begin
      op_en <= acc.wr_data[0];  // arm
    end else if (dp2reg_done && is_consumer) begin
      op_en <= 1'b0;            // layer finished
    end
  end

  //////////////////////////////////////////////////
  // config fields
  //////////////////////////////////////////////////
  always_ff @(posedge autosa_core_clk or negedge autosa_core_rstn) begin
    if (!autosa_core_rstn) begin
      cube_in_width     <= '0;
      cube_in_height    <= '0;
      cube_in_channel   <= '0;
      src_base_addr_low <= '0;
      src_line_stride   <= '0;
      dma_en            <= 1'b0;
    end else if (wr_ok) begin
      case (acc.offset)
        `PDP_RDMA_D_CUBE_WIDTH:      cube_in_width   <= acc.wr_data[$bits(cube_dim_t)-1:0];
        `PDP_RDMA_D_CUBE_HEIGHT:     cube_in_height  <= acc.wr_data[$bits(cube_dim_t)-1:0];
        `PDP_RDMA_D_CUBE_CHANNEL:    cube_in_channel <= acc.wr_data[$bits(cube_dim_t)-1:0];
        `PDP_RDMA_D_SRC_BASE_LOW:    src_base_addr_low <= acc.wr_data;
        `PDP_RDMA_D_SRC_LINE_STRIDE: src_line_stride   <= acc.wr_data;
        `PDP_RDMA_D_DMA_EN:          dma_en            <= acc.wr_data[0];
        default: ;  // op_en handled above, rest unmapped
      endcase
    end
  end

  //////////////////////////////////////////////////
  // read back
  //////////////////////////////////////////////////
  always_comb begin
    acc.rd_data = '0;
    case (acc.offset)
      `PDP_RDMA_D_OP_ENABLE:       acc.rd_data[0] = op_en;
      `PDP_RDMA_D_CUBE_WIDTH:      acc.rd_data = reg_data_t'(cube_in_width);
      `PDP_RDMA_D_CUBE_HEIGHT:     acc.rd_data = reg_data_t'(cube_in_height);
      `PDP_RDMA_D_CUBE_CHANNEL:    acc.rd_data = reg_data_t'(cube_in_channel);
      `PDP_RDMA_D_SRC_BASE_LOW:    acc.rd_data = src_base_addr_low;
      `PDP_RDMA_D_SRC_LINE_STRIDE: acc.rd_data = src_line_stride;
      `PDP_RDMA_D_DMA_EN:          acc.rd_data[0] = dma_en;
      default: ;  // zero
    endcase
  end

  // sw must wait for done before touching an armed group
  a_no_wr_when_armed : assert property (
    @(posedge autosa_core_clk) disable iff (!autosa_core_rstn)
    op_en |-> !acc.wr_en
  );

endmodule

/* verilog/group_pointer_regs.sv */
`include "pdp_rdma_defs.svh"

module group_pointer_regs
  import pdp_rdma_pkg::*;
(
  input  logic                            autosa_core_clk,
  input  logic                            autosa_core_rstn,
  reg_access_if.target                    acc,
  input  logic [`PDP_RDMA_GROUP_NUM-1:0]  op_en,
  input  logic                            dp2reg_done,
  output logic                            producer,
  output logic                            consumer
);

  group_status_e status [`PDP_RDMA_GROUP_NUM];

  //////////////////////////////////////////////////
  // producer / consumer pointers
  //////////////////////////////////////////////////
  always_ff @(posedge autosa_core_clk or negedge autosa_core_rstn) begin
    if (!autosa_core_rstn) begin
      producer <= 1'b0;
    end else if (acc.wr_en && acc.offset == `PDP_RDMA_S_POINTER) begin
      producer <= acc.wr_data[0];  // sw picks group for writes
    end
  end

  always_ff @(posedge autosa_core_clk or negedge autosa_core_rstn) begin
    if (!autosa_core_rstn) begin
      consumer <= 1'b0;
    end else if (dp2reg_done) begin
      consumer <= ~consumer;  // hw moves on to the other group
    end
  end

  // status per group
  for (genvar g = 0; g < `PDP_RDMA_GROUP_NUM; g++) begin : g_status
    always_comb begin
      if (!op_en[g]) begin
        status[g] = GROUP_IDLE;
      end else if (consumer == 1'(g)) begin
        status[g] = GROUP_RUNNING;
      end else begin
        status[g] = GROUP_PENDING;
      end
    end
  end

  //////////////////////////////////////////////////
  // read mux
  //////////////////////////////////////////////////
  always_comb begin
    acc.rd_data = '0;  // unmapped reads zero
    case (acc.offset)
      `PDP_RDMA_S_POINTER: begin
        acc.rd_data[0]                      = producer;
        acc.rd_data[`PDP_RDMA_CONSUMER_BIT] = consumer;  // ro
      end
      `PDP_RDMA_S_STATUS: begin
        acc.rd_data[1:0] = status[0];
        acc.rd_data[`PDP_RDMA_STATUS_1_LSB +: 2] = status[1];
      end
      default: ;
    endcase
  end

  // done comes straight from the datapath
  a_done_known : assert property (
    @(posedge autosa_core_clk) disable iff (!autosa_core_rstn)
    !$isunknown(dp2reg_done)
  );

endmodule

/* verilog/csb_req_decode.sv */
`include "pdp_rdma_defs.svh"

module csb_req_decode
  import pdp_rdma_pkg::*;
(
  input  logic          autosa_core_clk,
  input  logic          autosa_core_rstn,
  input  csb_req_pd_t   csb2pdp_rdma_req_pd,
  input  logic          csb2pdp_rdma_req_pvld,
  input  logic          producer,          // picks the dual group for access
  reg_access_if.host    s_acc,
  reg_access_if.host    d_acc [`PDP_RDMA_GROUP_NUM],
  output csb_resp_pd_t  pdp_rdma2csb_resp_pd,
  output logic          pdp_rdma2csb_resp_valid
);

  csb_req_pd_t  req_pd;
  logic         req_pvld;
  csb_addr_t    req_addr;
  reg_data_t    req_wdat;
  logic         req_write;
  logic         req_nposted;
  reg_offset_t  reg_offset;
  logic         reg_wr_en;
  logic         reg_rd_en;
  logic         sel_dual;
  reg_data_t    d_rd_data [`PDP_RDMA_GROUP_NUM];
  reg_data_t    reg_rd_data;
  csb_resp_pd_t resp_pd_nxt;

  //////////////////////////////////////////////////
  // request capture
  //////////////////////////////////////////////////
  always_ff @(posedge autosa_core_clk or negedge autosa_core_rstn) begin
    if (!autosa_core_rstn) begin
      req_pvld <= 1'b0;
    end else begin
      req_pvld <= csb2pdp_rdma_req_pvld;
    end
  end

  always_ff @(posedge autosa_core_clk) begin
    if (csb2pdp_rdma_req_pvld) begin
      req_pd <= csb2pdp_rdma_req_pd;  // hold last packet otherwise
    end
  end

  // unpack, upper fields unused
  assign req_addr    = req_pd[`PDP_RDMA_REQ_ADDR_MSB:0];
  assign req_wdat    = req_pd[`PDP_RDMA_REQ_WDAT_MSB:`PDP_RDMA_REQ_WDAT_LSB];
  assign req_write   = req_pd[`PDP_RDMA_REQ_WRITE_BIT];
  assign req_nposted = req_pd[`PDP_RDMA_REQ_NPOSTED_BIT];

  // word addr -> byte offset, unit spans 4KB
  assign reg_offset = {req_addr[9:0], 2'b00};
  assign reg_wr_en  = req_pvld & req_write;
  assign reg_rd_en  = req_pvld & ~req_write;

  //////////////////////////////////////////////////
  // steer to single or producer's dual group
  //////////////////////////////////////////////////
  assign sel_dual = (reg_offset >= `PDP_RDMA_DUAL_BASE);

  assign s_acc.offset  = reg_offset;
  assign s_acc.wr_data = req_wdat;
  assign s_acc.wr_en   = reg_wr_en & ~sel_dual;

  for (genvar g = 0; g < `PDP_RDMA_GROUP_NUM; g++) begin : g_dual
    assign d_acc[g].offset  = reg_offset;
    assign d_acc[g].wr_data = req_wdat;
    assign d_acc[g].wr_en   = reg_wr_en & sel_dual & (producer == 1'(g));
    assign d_rd_data[g]     = d_acc[g].rd_data;  // flatten for the mux
  end

  assign reg_rd_data = sel_dual ? d_rd_data[producer] : s_acc.rd_data;

  //////////////////////////////////////////////////
  // response
  //////////////////////////////////////////////////
  always_comb begin
    resp_pd_nxt = '0;  // error bit stays 0
    if (req_write) begin
      resp_pd_nxt[`PDP_RDMA_RESP_WR_BIT] = 1'b1;  // write ack, no data
    end else begin
      resp_pd_nxt[31:0] = reg_rd_data;
    end
  end

  always_ff @(posedge autosa_core_clk or negedge autosa_core_rstn) begin
    if (!autosa_core_rstn) begin
      pdp_rdma2csb_resp_valid <= 1'b0;
      pdp_rdma2csb_resp_pd    <= '0;
    end else begin
      pdp_rdma2csb_resp_valid <= reg_rd_en | (reg_wr_en & req_nposted);  // posted wr silent
      if (reg_rd_en | (reg_wr_en & req_nposted)) begin
        pdp_rdma2csb_resp_pd <= resp_pd_nxt;
      end
    end
  end

  // decoded request fields must be known on a valid request
  a_req_known : assert property (
    @(posedge autosa_core_clk) disable iff (!autosa_core_rstn)
    csb2pdp_rdma_req_pvld |-> !$isunknown(csb2pdp_rdma_req_pd[`PDP_RDMA_REQ_NPOSTED_BIT:0])
  );

endmodule

/* verilog/reg_access_if.sv */
// register access between csb decoder and one register group
interface reg_access_if;

  pdp_rdma_pkg::reg_offset_t offset;   // byte offset, same for all targets
  pdp_rdma_pkg::reg_data_t   wr_data;
  logic                      wr_en;    // one cycle strobe
  pdp_rdma_pkg::reg_data_t   rd_data;  // combinational from offset

  modport host (
    output offset,
    output wr_data,
    output wr_en,
    input  rd_data
  );

  modport target (
    input  offset,
    input  wr_data,
    input  wr_en,
    output rd_data
  );

endinterface

/* verilog/pdp_rdma_pkg.sv */
package pdp_rdma_pkg;

  // csb packets
  typedef logic [62:0] csb_req_pd_t;   // level/wrbe/srcpriv kept in 62:56, not decoded
  typedef logic [33:0] csb_resp_pd_t;  // 33 wr ack, 32 error, 31:0 data

  // addressing
  typedef logic [21:0] csb_addr_t;     // word address from the bus
  typedef logic [11:0] reg_offset_t;   // byte offset within the 4KB unit

  // register payload
  typedef logic [31:0] reg_data_t;
  typedef logic [12:0] cube_dim_t;     // width/height/channel

  // per-group status as seen by sw
  typedef enum logic [1:0] {
    GROUP_IDLE    = 2'd0,   // op_en clear
    GROUP_PENDING = 2'd1,   // armed, waiting its turn
    GROUP_RUNNING = 2'd2    // armed and owned by the consumer
  } group_status_e;

endpackage

/* verilog/pdp_rdma_defs.svh */
`ifndef PDP_RDMA_DEFS_SVH
`define PDP_RDMA_DEFS_SVH

// ping-pong groups, one bit pointer so fixed at 2
`define PDP_RDMA_GROUP_NUM          2
`define PDP_RDMA_DUAL_BASE          12'h008  // offsets below go to the single group

// single group
`define PDP_RDMA_S_POINTER          12'h000  // producer bit 0, consumer bit 16
`define PDP_RDMA_S_STATUS           12'h004  // status_0 1:0, status_1 17:16
`define PDP_RDMA_CONSUMER_BIT       16
`define PDP_RDMA_STATUS_1_LSB       16

// duplicated groups
`define PDP_RDMA_D_OP_ENABLE        12'h008
`define PDP_RDMA_D_CUBE_WIDTH       12'h00c
`define PDP_RDMA_D_CUBE_HEIGHT      12'h010
`define PDP_RDMA_D_CUBE_CHANNEL     12'h014
`define PDP_RDMA_D_SRC_BASE_LOW     12'h018
`define PDP_RDMA_D_SRC_LINE_STRIDE  12'h01c
`define PDP_RDMA_D_DMA_EN           12'h020

// csb packet fields
`define PDP_RDMA_REQ_ADDR_MSB       21
`define PDP_RDMA_REQ_WDAT_LSB       22
`define PDP_RDMA_REQ_WDAT_MSB       53
`define PDP_RDMA_REQ_WRITE_BIT      54
`define PDP_RDMA_REQ_NPOSTED_BIT    55
`define PDP_RDMA_RESP_WR_BIT        33

`define PDP_RDMA_OP_EN_DEPTH        3    // launch pipe stages

`endif
